/* m92_pic_top.f */
+incdir+source
source/pic_pkg.sv
source/pic_command_decoder.sv
source/pic_request_cell.sv
source/pic_priority_resolver.sv
source/m92_pic_top.sv
testbench/pic_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the interrupt controller testbench with Verilator and run it.
# The result is taken from the simulation log.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f m92_pic_top.f \
    --top-module pic_tb \
    -o pic_sim

./obj_dir/pic_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* testbench/pic_tb.sv */
/*
 * Interrupt controller testbench
 * Random bus and interrupt stimulus checked against a cycle model
 */

`timescale 1ns/1ps
`default_nettype none

`include "pic_params.svh"

module pic_tb
    import pic_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int ROUNDS       = 16;
    localparam int RUN_CYCLES   = 400;
    localparam int INIT_BUDGET  = 40;
    localparam int TEST_CYCLES  = RESET_CYCLES + INIT_BUDGET + ROUNDS * (RUN_CYCLES + INIT_BUDGET);
    localparam int WATCHDOG_NS  = TEST_CYCLES * 10 + 2000;

    logic       clk = 1'b0;
    logic       reset;
    logic       ce;
    logic       cs;
    logic       wr;
    logic       a0;
    bus_byte_t  din;
    irq_lines_t intp;
    logic       int_ack;
    logic       int_req;
    vector_t    int_vector;

    logic [31:0] rng = 32'hcd06_939b;
    int          errors = 0;
    int          checks = 0;
    int          acks = 0;

    // Bus write that stays on the strobes until an enabled edge takes it
    logic      bus_busy = 1'b0;
    logic      bus_a0 = 1'b0;
    bus_byte_t bus_din = '0;

    // Reference model state
    init_state_t  m_state = st_uninit;
    logic         m_need4 = 1'b0;
    logic         m_single = 1'b0;
    logic         m_level = 1'b0;
    vector_base_t m_base = '0;
    irq_lines_t   m_mask = '0;
    irq_lines_t   m_pend = '0;
    irq_lines_t   m_prev = '0;
    vector_t      m_vector = '0;

    m92_pic_top DUT (
        .clk        (clk),
        .reset      (reset),
        .ce         (ce),
        .cs         (cs),
        .wr         (wr),
        .a0         (a0),
        .din        (din),
        .intp       (intp),
        .int_ack    (int_ack),
        .int_req    (int_req),
        .int_vector (int_vector)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // ========================================================================
    // Cycle model stepped once per rising edge with the sampled inputs
    // ========================================================================

    task automatic model_step();
        logic       bus_wr;
        logic       init_start;
        logic       data_wr;
        logic       m_ready;
        logic       trig;
        irq_lines_t active;
        irq_lines_t grant;
        int         low;
        if (ce) begin
            bus_wr     = cs & wr;
            init_start = bus_wr & ~a0 & din[4];
            data_wr    = bus_wr & a0;
            m_ready    = (m_state == st_ready);
            active     = m_pend & ~m_mask;
            grant      = '0;
            low        = -1;
            // Line 0 has the highest priority
            for (int i = 0; i < `PIC_LINES; i++) begin
                if (active[i] && low < 0) begin
                    low = i;
                end
            end
            if (m_ready && int_ack && low >= 0) begin
                grant[low] = 1'b1;
                m_vector   = (vector_t'(m_base) << 5) | (vector_t'(low) << 2);
                acks++;
            end
            for (int i = 0; i < `PIC_LINES; i++) begin
                trig = m_level ? intp[i] : (intp[i] & ~m_prev[i]);
                if (init_start) begin
                    m_pend[i] = 1'b0;
                end else if (m_ready && trig) begin
                    m_pend[i] = 1'b1;
                end else if (grant[i]) begin
                    m_pend[i] = 1'b0;
                end
                if (m_ready) begin
                    m_prev[i] = intp[i];
                end
            end
            if (init_start) begin
                m_state  = st_wait_iw2;
                m_need4  = din[0];
                m_single = din[1];
                m_level  = din[3];
                m_mask   = '0;
            end else if (data_wr) begin
                case (m_state)
                    st_wait_iw2: begin
                        m_base = din[6:3];
                        if (!m_single) begin
                            m_state = st_wait_iw3;
                        end else begin
                            m_state = m_need4 ? st_wait_iw4 : st_ready;
                        end
                    end
                    st_wait_iw3: m_state = m_need4 ? st_wait_iw4 : st_ready;
                    st_wait_iw4: m_state = st_ready;
                    st_ready:    m_mask = din;
                    default:     m_state = m_state;
                endcase
            end
        end
    endtask

    // Each cycle steps the model, drives new inputs and compares at the falling edge
    task automatic tick();
        logic model_req;
        @(posedge clk);
        if (ce && cs && wr) begin
            bus_busy = 1'b0;
        end
        model_step();
        ce      <= (rand32() % 4) != 0;
        cs      <= bus_busy;
        wr      <= bus_busy;
        a0      <= bus_a0;
        din     <= bus_din;
        int_ack <= (rand32() % 3) == 0;
        // Lines change now and then so that some stay high for many cycles
        if ((rand32() % 4) == 0) begin
            intp <= irq_lines_t'(rand32());
        end
        @(negedge clk);
        model_req = |(m_pend & ~m_mask);
        check("int_req", 32'(int_req), 32'(model_req));
        check("int_vector", 32'(int_vector), 32'(m_vector));
    endtask

    task automatic bus_write(input logic port, input bus_byte_t data);
        // A random write left over from the traffic run goes out first
        while (bus_busy) begin
            tick();
        end
        bus_a0   = port;
        bus_din  = data;
        bus_busy = 1'b1;
        while (bus_busy) begin
            tick();
        end
    endtask

    // Random traffic with mask loads and ignored command words mixed in
    task automatic run_random(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            if (!bus_busy && (rand32() % 20) == 0) begin
                bus_busy = 1'b1;
                if ((rand32() % 3) != 0) begin
                    bus_a0  = 1'b1;
                    bus_din = ((rand32() % 3) == 0) ? 8'h00 : bus_byte_t'(rand32());
                end else begin
                    bus_a0  = 1'b0;
                    bus_din = bus_byte_t'(rand32()) & 8'hef;
                end
            end
            tick();
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        bus_byte_t   iw1;
        logic [2:0]  cfg;
        reset   = 1'b1;
        ce      = 1'b0;
        cs      = 1'b0;
        wr      = 1'b0;
        a0      = 1'b0;
        din     = '0;
        intp    = '0;
        int_ack = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Writes before the first initialization word change nothing
        bus_write(1'b1, 8'h5a);
        bus_write(1'b0, 8'h0b);

        for (int r = 0; r < ROUNDS; r++) begin
            // cfg bit 2 selects level mode, bit 1 single mode, bit 0 the fourth word
            cfg = 3'(r % 8);
            iw1 = (bus_byte_t'(rand32()) & 8'he4) | 8'h10 | {4'b0, cfg[2], 1'b0, cfg[1:0]};
            bus_write(1'b0, iw1);
            bus_write(1'b1, bus_byte_t'(rand32()));
            if (!cfg[1]) begin
                bus_write(1'b1, bus_byte_t'(rand32()));
            end
            if (cfg[0]) begin
                bus_write(1'b1, bus_byte_t'(rand32()));
            end
            run_random(RUN_CYCLES);
        end

        if (acks == 0) begin
            errors++;
            $display("no acknowledge was accepted during the whole run");
        end
        $display("checks: %0d, errors: %0d, acknowledges: %0d", checks, errors, acks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* source/m92_pic_top.sv */
/*
 * Programmable interrupt controller, top level
 * Command decoder, one request cell per line and the priority resolver
 */

`timescale 1ns/1ps
`default_nettype none

`include "pic_params.svh"

module m92_pic_top
    import pic_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  logic       cs,
    input  logic       wr,
    input  logic       a0,
    input  bus_byte_t  din,
    input  irq_lines_t intp,
    input  logic       int_ack,
    output logic       int_req,
    output vector_t    int_vector
);

    logic         ready;
    logic         edge_mode;
    logic         init_clear;
    irq_lines_t   mask;
    vector_base_t vector_base;
    irq_lines_t   requests;
    irq_lines_t   grant;

    pic_command_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .cs          (cs),
        .wr          (wr),
        .a0          (a0),
        .din         (din),
        .ready       (ready),
        .edge_mode   (edge_mode),
        .init_clear  (init_clear),
        .mask        (mask),
        .vector_base (vector_base)
    );

    // ========================================================================
    // One request cell per interrupt line
    // ========================================================================

    for (genvar i = 0; i < `PIC_LINES; i++) begin : g_cell
        pic_request_cell u_cell (
            .clk        (clk),
            .reset      (reset),
            .ce         (ce),
            .ready      (ready),
            .edge_mode  (edge_mode),
            .init_clear (init_clear),
            .line       (intp[i]),
            .grant      (grant[i]),
            .pending    (requests[i])
        );
    end

    pic_priority_resolver u_resolver (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .ready       (ready),
        .requests    (requests),
        .mask        (mask),
        .vector_base (vector_base),
        .int_ack     (int_ack),
        .int_req     (int_req),
        .grant       (grant),
        .int_vector  (int_vector)
    );

endmodule

`default_nettype wire

/* source/pic_priority_resolver.sv */
/*
 * Interrupt priority resolver
 * Masks requests, raises int_req and grants the lowest unmasked line on acknowledge
 */

`timescale 1ns/1ps
`default_nettype none

`include "pic_params.svh"

module pic_priority_resolver
    import pic_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ce,
    input  logic         ready,
    input  irq_lines_t   requests,
    input  irq_lines_t   mask,
    input  vector_base_t vector_base,
    input  logic         int_ack,
    output logic         int_req,
    output irq_lines_t   grant,
    output vector_t      int_vector
);

    localparam int LINE_W = $clog2(`PIC_LINES);

    irq_lines_t        active;
    irq_lines_t        pick;
    logic [LINE_W-1:0] pick_num;
    logic              accept;

    assign active  = requests & ~mask;
    assign int_req = |active;

    // Line 0 has the highest priority. Scanning downwards lets the
    // lowest active line overwrite any higher one
    always_comb begin
        pick     = '0;
        pick_num = '0;
        for (int i = `PIC_LINES - 1; i >= 0; i--) begin
            if (active[i]) begin
                pick     = '0;
                pick[i]  = 1'b1;
                pick_num = LINE_W'(i);
            end
        end
    end

    assign accept = ce & ready & int_ack & int_req;

    // Grant clears the pending bit on the same edge the vector loads
    assign grant = accept ? pick : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            int_vector <= '0;
        end else if (accept) begin
            int_vector <= {vector_base, pick_num, 2'b00};
        end
    end

endmodule

`default_nettype wire

/* source/pic_request_cell.sv */
/*
 * Interrupt request cell
 * Pending bit of one line with edge or level capture
 */

`timescale 1ns/1ps
`default_nettype none

`include "pic_params.svh"

module pic_request_cell
    import pic_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic ce,
    input  logic ready,
    input  logic edge_mode,
    input  logic init_clear,
    input  logic line,
    input  logic grant,
    output logic pending
);

    logic line_prev;
    logic trigger;

    // Edge mode needs a low sample before the high one
    assign trigger = edge_mode ? (line & ~line_prev) : line;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            line_prev <= 1'b0;
            pending   <= 1'b0;
        end else if (ce) begin
            if (ready) begin
                line_prev <= line;
            end

            // A new capture beats a grant arriving on the same edge
            if (init_clear) begin
                pending <= 1'b0;
            end else if (ready && trigger) begin
                pending <= 1'b1;
            end else if (grant) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/pic_command_decoder.sv */
/*
 * Interrupt controller command decoder
 * Runs the initialization sequence and holds the mode bits, mask and vector base
 */

`timescale 1ns/1ps
`default_nettype none

`include "pic_params.svh"

module pic_command_decoder
    import pic_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ce,
    input  logic         cs,
    input  logic         wr,
    input  logic         a0,
    input  bus_byte_t    din,
    output logic         ready,
    output logic         edge_mode,
    output logic         init_clear,
    output irq_lines_t   mask,
    output vector_base_t vector_base
);

    init_state_t state;

    // Mode bits kept from the first initialization word
    logic iw1_need_iw4;
    logic iw1_single;
    logic iw1_level;

    logic bus_write;
    logic init_start;
    logic data_write;

    // ========================================================================
    // Write decode
    // ========================================================================

    assign bus_write = ce & cs & wr;

    // Control port with bit 4 set starts a new sequence; other control
    // port writes are command words and are ignored
    assign init_start = bus_write & ~a0 & din[4];

    // Data port writes advance the sequence or load the mask
    assign data_write = bus_write & a0;

    assign init_clear = init_start;

    assign ready     = (state == st_ready);
    assign edge_mode = ~iw1_level;

    // ========================================================================
    // Initialization FSM and mask
    // ========================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= st_uninit;
            iw1_need_iw4 <= 1'b0;
            iw1_single   <= 1'b0;
            iw1_level    <= 1'b0;
            mask         <= '0;
        end else if (init_start) begin
            state        <= st_wait_iw2;
            iw1_need_iw4 <= din[0];
            iw1_single   <= din[1];
            iw1_level    <= din[3];
            mask         <= '0;
        end else if (data_write) begin
            case (state)
                st_wait_iw2: begin
                    // Extended mode always expects the third word
                    if (!iw1_single) begin
                        state <= st_wait_iw3;
                    end else if (iw1_need_iw4) begin
                        state <= st_wait_iw4;
                    end else begin
                        state <= st_ready;
                    end
                end
                st_wait_iw3: begin
                    if (iw1_need_iw4) begin
                        state <= st_wait_iw4;
                    end else begin
                        state <= st_ready;
                    end
                end
                st_wait_iw4: begin
                    state <= st_ready;
                end
                st_ready: begin
                    mask <= irq_lines_t'(din);
                end
                default: begin
                    // Data writes before the first word have no effect
                    state <= state;
                end
            endcase
        end
    end

    // Vector base comes from bits 6 to 3 of the second word
    always_ff @(posedge clk) begin
        if (data_write && state == st_wait_iw2) begin
            vector_base <= din[3 +: `PIC_BASE_W];
        end
    end

endmodule

`default_nettype wire

/* source/pic_pkg.sv */
/*
 * Interrupt controller types
 * Vector types for lines, vectors and bus bytes, plus the init FSM states
 */

`default_nettype none

`include "pic_params.svh"

package pic_pkg;

    typedef logic [`PIC_LINES-1:0]    irq_lines_t;
    typedef logic [`PIC_VECTOR_W-1:0] vector_t;
    typedef logic [`PIC_BASE_W-1:0]   vector_base_t;
    typedef logic [7:0]               bus_byte_t;

    // Initialization sequence, one state per expected data-port word
    typedef enum logic [2:0] {
        st_uninit,
        st_wait_iw2,
        st_wait_iw3,
        st_wait_iw4,
        st_ready
    } init_state_t;

endpackage

`default_nettype wire

/* source/pic_params.svh */
/*
 * Interrupt controller parameters
 * Line count and the widths of the vector and its base
 */

`ifndef PIC_PARAMS_SVH
`define PIC_PARAMS_SVH

// Number of interrupt lines handled by the controller
`define PIC_LINES 8

// Vector layout is base, line number, then two zero bits
`define PIC_VECTOR_W 9

// Base field taken from the second initialization word
`define PIC_BASE_W 4

`endif
